// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vga_frame_buffer
FILELIST  ?= vga_frame_buffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation FAILED"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/vga_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vga_frame_buffer (
    input  logic                sys_clk,
    input  logic                sys_rst,
    // drawing master
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  vga_pkg::fb_index_t  wb_adr,
    input  vga_pkg::sram_word_t wb_dat_i,
    output vga_pkg::sram_word_t wb_dat_o,
    output logic                wb_ack,
    // display
    output vga_pkg::pixel_t     vga_rgb,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de,
    // external sram
    output logic                sram_ce_n,
    output logic                sram_oe_n,
    output logic                sram_we_n,
    output vga_pkg::sram_addr_t sram_addr,
    output vga_pkg::sram_word_t sram_dq_write,
    output logic                sram_dq_en,
    input  vga_pkg::sram_word_t sram_dq_read
);

    // ----------------------------------------
    // internal wires
    // ----------------------------------------
    logic                bus_req;
    logic                bus_we;
    vga_pkg::sram_addr_t bus_addr;
    vga_pkg::sram_word_t bus_wdata;
    vga_pkg::sram_word_t bus_rdata;
    logic                bus_done;
    logic                fetch_req;
    logic                fetch_grant;
    vga_pkg::sram_addr_t fetch_addr;
    logic                fifo_push;
    logic                fifo_pop;
    vga_pkg::sram_word_t fifo_din;
    vga_pkg::sram_word_t fifo_dout;
    logic                fifo_full;
    logic                fifo_afull;

    vga_wb_port u_wb_port (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_done  (bus_done)
    );

    // single owner of the sram pins
    vga_sram_arbiter u_arbiter (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_grant   (fetch_grant),
        .bus_req       (bus_req),
        .bus_we        (bus_we),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_done      (bus_done),
        .bus_rdata     (bus_rdata),
        .fifo_push     (fifo_push),
        .fifo_din      (fifo_din),
        .sram_ce_n     (sram_ce_n),
        .sram_oe_n     (sram_oe_n),
        .sram_we_n     (sram_we_n),
        .sram_addr     (sram_addr),
        .sram_dq_write (sram_dq_write),
        .sram_dq_en    (sram_dq_en),
        .sram_dq_read  (sram_dq_read)
    );

    vga_scan_fetch u_scan_fetch (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .almost_full (fifo_afull),
        .fetch_grant (fetch_grant),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr)
    );

    vga_pixel_fifo u_pixel_fifo (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .push        (fifo_push),
        .din         (fifo_din),
        .pop         (fifo_pop),
        .dout        (fifo_dout),
        .full        (fifo_full),
        .almost_full (fifo_afull)
    );

    vga_timing u_timing (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .fifo_full (fifo_full),
        .fifo_dout (fifo_dout),
        .fifo_pop  (fifo_pop),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de)
    );

endmodule

`default_nettype wire

// File: design/vga_pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_fifo (
    input  logic                sys_clk,
    input  logic                sys_rst,
    input  logic                push,
    input  vga_pkg::sram_word_t din,
    input  logic                pop,
    output vga_pkg::sram_word_t dout,
    output logic                full,
    output logic                almost_full
);

    vga_pkg::sram_word_t        mem [vga_pkg::fifo_depth];
    logic [vga_pkg::fifo_aw-1:0] wr_ptr;
    logic [vga_pkg::fifo_aw-1:0] rd_ptr;
    logic [vga_pkg::fifo_aw:0]   count;
    logic [vga_pkg::fifo_aw:0]   level;
    logic                        empty;

    // first word falls through
    assign dout  = mem[rd_ptr];
    assign full  = (count == (vga_pkg::fifo_aw + 1)'(vga_pkg::fifo_depth));
    assign empty = (count == '0);

    // stored words plus the push in flight, one more slot kept
    // for the read issued in the previous cycle
    assign level       = count + (vga_pkg::fifo_aw + 1)'(push);
    assign almost_full = (level >= (vga_pkg::fifo_aw + 1)'(vga_pkg::fifo_depth - 1));

    always_ff @(posedge sys_clk) begin
        if (push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fetch throttling must keep the arbiter from overrunning us
    no_push_full: assert property (@(posedge sys_clk) disable iff (sys_rst)
        push |-> !full || pop);
    // display must never run ahead of the fetch
    no_pop_empty: assert property (@(posedge sys_clk) disable iff (sys_rst)
        pop |-> !empty);

endmodule

`default_nettype wire

// File: design/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // ----------------------------------------
    // raster timing
    // ----------------------------------------

    // horizontal, in pixels
    localparam int h_display = 16;
    localparam int h_front   = 2;
    localparam int h_sync    = 3;
    localparam int h_back    = 3;
    localparam int h_total   = h_display + h_front + h_sync + h_back;

    // vertical, in lines
    localparam int v_display = 8;
    localparam int v_front   = 1;
    localparam int v_sync    = 2;
    localparam int v_back    = 1;
    localparam int v_total   = v_display + v_front + v_sync + v_back;

    // sys_clk cycles per pixel
    localparam int pixel_div = 4;

    // ----------------------------------------
    // widths and fifo sizing
    // ----------------------------------------
    localparam int sram_aw    = 18;
    localparam int sram_dw    = 16;
    localparam int rgb_w      = 12;
    localparam int fifo_depth = 8;
    localparam int fifo_aw    = 3;

    typedef logic [sram_aw-1:0] sram_addr_t;
    typedef logic [sram_dw-1:0] sram_word_t;
    typedef logic [rgb_w-1:0]   pixel_t;
    typedef logic [4:0]         hpos_t;
    // y in the top 3 bits, x in the low 4
    typedef logic [6:0]         fb_index_t;

    // who owns the sram access in the current cycle
    typedef enum logic [1:0] {idle, fetch, bus} arb_state_t;
    typedef enum logic {wait_req, wait_done} wb_state_t;
    typedef logic [3:0]         vpos_t;

endpackage

`default_nettype wire

// File: design/vga_scan_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module vga_scan_fetch (
    input  logic                sys_clk,
    input  logic                sys_rst,
    input  logic                almost_full,
    input  logic                fetch_grant,
    output logic                fetch_req,
    output vga_pkg::sram_addr_t fetch_addr
);

    // counters span the visible raster only
    logic [$clog2(vga_pkg::h_display)-1:0] x;
    logic [$clog2(vga_pkg::v_display)-1:0] y;
    vga_pkg::fb_index_t                    pix;

    // width is a power of two, so y*16+x is a concatenation
    assign pix        = {y, x};
    assign fetch_addr = vga_pkg::sram_addr_t'(pix);

    // keep asking while the fifo can take another word
    assign fetch_req = !almost_full;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            x <= '0;
            y <= '0;
        end else if (fetch_grant) begin
            if (x == ($bits(x))'(vga_pkg::h_display - 1)) begin
                x <= '0;
                // last pixel of the frame wraps to the top
                if (y == ($bits(y))'(vga_pkg::v_display - 1)) y <= '0;
                else                                          y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/vga_sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vga_sram_arbiter (
    input  logic                sys_clk,
    input  logic                sys_rst,
    // display fetch
    input  logic                fetch_req,
    input  vga_pkg::sram_addr_t fetch_addr,
    output logic                fetch_grant,
    // wishbone side
    input  logic                bus_req,
    input  logic                bus_we,
    input  vga_pkg::sram_addr_t bus_addr,
    input  vga_pkg::sram_word_t bus_wdata,
    output logic                bus_done,
    output vga_pkg::sram_word_t bus_rdata,
    // pixel fifo write side
    output logic                fifo_push,
    output vga_pkg::sram_word_t fifo_din,
    // sram pins
    output logic                sram_ce_n,
    output logic                sram_oe_n,
    output logic                sram_we_n,
    output vga_pkg::sram_addr_t sram_addr,
    output vga_pkg::sram_word_t sram_dq_write,
    output logic                sram_dq_en,
    input  vga_pkg::sram_word_t sram_dq_read
);

    // ----------------------------------------
    // issue stage
    // ----------------------------------------
    vga_pkg::arb_state_t next_state;
    vga_pkg::arb_state_t issue_state;
    vga_pkg::arb_state_t ret_state;
    vga_pkg::sram_addr_t issue_addr;
    vga_pkg::sram_word_t issue_wdata;
    vga_pkg::sram_word_t ret_data;
    logic                issue_we;
    logic                bus_block;

    // held bus request is already on the pins or returning
    assign bus_block = (issue_state == vga_pkg::bus) || (ret_state == vga_pkg::bus);

    // display fetch always wins
    always_comb begin
        next_state = vga_pkg::idle;
        if (fetch_req)                   next_state = vga_pkg::fetch;
        else if (bus_req && !bus_block)  next_state = vga_pkg::bus;
    end

    assign fetch_grant = (next_state == vga_pkg::fetch);

    always_ff @(posedge sys_clk) begin
        if (sys_rst) issue_state <= vga_pkg::idle;
        else         issue_state <= next_state;
    end

    // address and write data follow the winner
    always_ff @(posedge sys_clk) begin
        issue_addr  <= fetch_req ? fetch_addr : bus_addr;
        issue_we    <= bus_we && !fetch_req;
        issue_wdata <= bus_wdata;
    end

    // pins are decoded from the issue register only
    assign sram_ce_n     = (issue_state == vga_pkg::idle);
    assign sram_we_n     = !((issue_state == vga_pkg::bus) && issue_we);
    assign sram_oe_n     = !((issue_state == vga_pkg::fetch) ||
                             ((issue_state == vga_pkg::bus) && !issue_we));
    assign sram_addr     = issue_addr;
    assign sram_dq_write = issue_wdata;
    assign sram_dq_en    = !sram_we_n;

    // ----------------------------------------
    // return stage
    // ----------------------------------------
    always_ff @(posedge sys_clk) begin
        if (sys_rst) ret_state <= vga_pkg::idle;
        else         ret_state <= issue_state;
    end

    // async read data is sampled at the end of the access cycle
    always_ff @(posedge sys_clk) begin
        ret_data <= sram_dq_read;
    end

    assign fifo_push = (ret_state == vga_pkg::fetch);
    assign fifo_din  = ret_data;
    assign bus_done  = (ret_state == vga_pkg::bus);
    assign bus_rdata = ret_data;

    // a waiting bus request stays up until its done pulse
    bus_req_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
        bus_req && !bus_done |=> bus_req);

endmodule

`default_nettype wire

// File: design/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic                sys_clk,
    input  logic                sys_rst,
    input  logic                fifo_full,
    input  vga_pkg::sram_word_t fifo_dout,
    output logic                fifo_pop,
    output vga_pkg::pixel_t     vga_rgb,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de
);

    logic [$clog2(vga_pkg::pixel_div)-1:0] div;
    logic                                  tick;
    logic                                  started;
    vga_pkg::hpos_t                        h;
    vga_pkg::vpos_t                        v;
    logic                                  visible;
    logic                                  h_sync_on;
    logic                                  v_sync_on;

    // ----------------------------------------
    // pixel tick and start
    // ----------------------------------------
    assign tick = (div == ($bits(div))'(vga_pkg::pixel_div - 1));

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            div     <= '0;
            started <= 1'b0;
        end else begin
            div <= div + 1'b1;
            // first full fifo opens the raster, never closes again
            if (fifo_full) started <= 1'b1;
        end
    end

    // ----------------------------------------
    // raster position and outputs
    // ----------------------------------------
    assign visible   = (h < vga_pkg::hpos_t'(vga_pkg::h_display)) &&
                       (v < vga_pkg::vpos_t'(vga_pkg::v_display));
    assign h_sync_on = (h >= vga_pkg::hpos_t'(vga_pkg::h_display + vga_pkg::h_front)) &&
                       (h < vga_pkg::hpos_t'(vga_pkg::h_total - vga_pkg::h_back));
    assign v_sync_on = (v >= vga_pkg::vpos_t'(vga_pkg::v_display + vga_pkg::v_front)) &&
                       (v < vga_pkg::vpos_t'(vga_pkg::v_total - vga_pkg::v_back));

    // one word leaves the fifo per visible pixel
    assign fifo_pop = tick && started && visible;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            h         <= '0;
            v         <= '0;
            vga_rgb   <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
        end else if (tick && started) begin
            vga_rgb   <= visible ? fifo_dout[vga_pkg::rgb_w-1:0] : '0;
            vga_de    <= visible;
            // both syncs are active low
            vga_hsync <= !h_sync_on;
            vga_vsync <= !v_sync_on;
            if (h == vga_pkg::hpos_t'(vga_pkg::h_total - 1)) begin
                h <= '0;
                if (v == vga_pkg::vpos_t'(vga_pkg::v_total - 1)) v <= '0;
                else                                             v <= v + 1'b1;
            end else begin
                h <= h + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/vga_wb_port.sv
`timescale 1ns/1ps
`default_nettype none

module vga_wb_port (
    input  logic                sys_clk,
    input  logic                sys_rst,
    // wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  vga_pkg::fb_index_t  wb_adr,
    input  vga_pkg::sram_word_t wb_dat_i,
    output vga_pkg::sram_word_t wb_dat_o,
    output logic                wb_ack,
    // request towards the arbiter
    output logic                bus_req,
    output logic                bus_we,
    output vga_pkg::sram_addr_t bus_addr,
    output vga_pkg::sram_word_t bus_wdata,
    input  vga_pkg::sram_word_t bus_rdata,
    input  logic                bus_done
);

    vga_pkg::wb_state_t state;
    logic               new_cycle;

    // strobe still high during ack belongs to the finished cycle
    assign new_cycle = wb_cyc && wb_stb && !wb_ack && (state == vga_pkg::wait_req);

    // request is raised in the strobe cycle and held until done
    assign bus_req   = new_cycle || (state == vga_pkg::wait_done);
    assign bus_we    = wb_we;
    // pixel index is the low part of the word address
    assign bus_addr  = vga_pkg::sram_addr_t'(wb_adr);
    assign bus_wdata = wb_dat_i;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state  <= vga_pkg::wait_req;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            case (state)
                vga_pkg::wait_req: begin
                    if (new_cycle) state <= vga_pkg::wait_done;
                end
                default: begin
                    if (bus_done) begin
                        state  <= vga_pkg::wait_req;
                        wb_ack <= 1'b1;
                    end
                end
            endcase
        end
    end

    // read word lines up with ack
    always_ff @(posedge sys_clk) begin
        if (bus_done) wb_dat_o <= bus_rdata;
    end

    // arbiter answers only a request that is still pending here
    done_only_when_pending: assert property (@(posedge sys_clk) disable iff (sys_rst)
        bus_done |-> (state == vga_pkg::wait_done));

endmodule

`default_nettype wire

// File: tb/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral sram with an asynchronous read port
module sram_model (
    input  logic                sys_clk,
    input  logic                ce_n,
    input  logic                oe_n,
    input  logic                we_n,
    input  vga_pkg::sram_addr_t addr,
    input  vga_pkg::sram_word_t dq_write,
    input  logic                dq_en,
    output vga_pkg::sram_word_t dq_read
);

    // whole address space of the part
    vga_pkg::sram_word_t mem [2**vga_pkg::sram_aw];

    // write needs select, write strobe and the data driver enabled
    always_ff @(posedge sys_clk) begin
        if (!ce_n && !we_n && dq_en) mem[addr] <= dq_write;
    end

    // combinational read while selected and output enabled
    // undriven bus reads as zero
    assign dq_read = (!ce_n && !oe_n) ? mem[addr] : '0;

endmodule

`default_nettype wire

// File: tb/tb_vga_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_frame_buffer;

    // 128 pixel pattern plus a few overwrites
    localparam int tbl_len   = 132;
    localparam int rand_ops  = 32;
    localparam int half_per  = 20;
    localparam int frame_px  = vga_pkg::v_total * vga_pkg::h_total;
    localparam int num_px    = vga_pkg::h_display * vga_pkg::v_display;
    localparam int watchdog_cycles = tbl_len * 20 +
        6 * vga_pkg::v_total * vga_pkg::h_total * vga_pkg::pixel_div;

    logic                sys_clk;
    logic                sys_rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    vga_pkg::fb_index_t  wb_adr;
    vga_pkg::sram_word_t wb_dat_i;
    vga_pkg::sram_word_t wb_dat_o;
    logic                wb_ack;
    vga_pkg::pixel_t     vga_rgb;
    logic                vga_hsync;
    logic                vga_vsync;
    logic                vga_de;
    logic                sram_ce_n;
    logic                sram_oe_n;
    logic                sram_we_n;
    vga_pkg::sram_addr_t sram_addr;
    vga_pkg::sram_word_t sram_dq_write;
    logic                sram_dq_en;
    vga_pkg::sram_word_t sram_dq_read;

    // stimulus table and the image it should leave in memory
    vga_pkg::fb_index_t  tbl_idx [tbl_len];
    vga_pkg::sram_word_t tbl_dat [tbl_len];
    vga_pkg::sram_word_t expected_image [num_px];
    integer              seed = 32'h8b3d3373;

    vga_frame_buffer dut0 (
        .sys_clk (sys_clk), .sys_rst (sys_rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o), .wb_ack (wb_ack),
        .vga_rgb (vga_rgb), .vga_hsync (vga_hsync), .vga_vsync (vga_vsync),
        .vga_de (vga_de),
        .sram_ce_n (sram_ce_n), .sram_oe_n (sram_oe_n), .sram_we_n (sram_we_n),
        .sram_addr (sram_addr), .sram_dq_write (sram_dq_write),
        .sram_dq_en (sram_dq_en), .sram_dq_read (sram_dq_read)
    );

    sram_model sram0 (
        .sys_clk (sys_clk), .ce_n (sram_ce_n), .oe_n (sram_oe_n), .we_n (sram_we_n),
        .addr (sram_addr), .dq_write (sram_dq_write), .dq_en (sram_dq_en),
        .dq_read (sram_dq_read)
    );

    initial sys_clk = 1'b0;
    always #half_per sys_clk = ~sys_clk;

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input vga_pkg::sram_word_t got,
                              input vga_pkg::sram_word_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pixel(input vga_pkg::pixel_t got,
                               input vga_pkg::pixel_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pos(input vga_pkg::hpos_t got,
                             input vga_pkg::hpos_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input vga_pkg::vpos_t got,
                              input vga_pkg::vpos_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reset_outputs();
        check_level(wb_ack, 1'b0, "wb_ack after reset");
        check_level(sram_ce_n, 1'b1, "sram_ce_n after reset");
        check_level(sram_oe_n, 1'b1, "sram_oe_n after reset");
        check_level(sram_we_n, 1'b1, "sram_we_n after reset");
        check_level(sram_dq_en, 1'b0, "sram_dq_en after reset");
        check_level(vga_de, 1'b0, "vga_de after reset");
        check_level(vga_hsync, 1'b1, "vga_hsync after reset");
    endtask

    // ----------------------------------------
    // wishbone master
    // ----------------------------------------
    // all tasks start and end on a falling edge
    task automatic wait_ack();
        @(negedge sys_clk);
        while (!wb_ack) @(negedge sys_clk);
    endtask

    // drop the strobe and make sure the ack does not repeat
    task automatic release_bus();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge sys_clk);
        check_level(wb_ack, 1'b0, "ack after end of cycle");
    endtask

    task automatic write_word(input vga_pkg::fb_index_t adr, input vga_pkg::sram_word_t dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = dat;
        wait_ack();
        release_bus();
    endtask

    task automatic read_word(input vga_pkg::fb_index_t adr, output vga_pkg::sram_word_t dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        // read data is valid in the ack cycle
        dat = wb_dat_o;
        release_bus();
    endtask

    // ----------------------------------------
    // display checks
    // ----------------------------------------
    task automatic wait_vsync_fall();
        logic prev;
        prev = vga_vsync;
        @(negedge sys_clk);
        while (!(prev && !vga_vsync)) begin
            prev = vga_vsync;
            @(negedge sys_clk);
        end
    endtask

    // one sample per pixel, aligned to the vsync edge
    task automatic check_frame();
        int                 p;
        int                 s;
        logic               prev_hs;
        logic               prev_vs;
        vga_pkg::fb_index_t idx;
        vga_pkg::hpos_t     de_in_line;
        vga_pkg::vpos_t     lines;
        vga_pkg::vpos_t     hs_pulses;
        vga_pkg::vpos_t     vs_extra;
        // second vsync edge leaves no stale word in the fifo
        wait_vsync_fall();
        wait_vsync_fall();
        p          = 0;
        de_in_line = '0;
        lines      = '0;
        hs_pulses  = '0;
        vs_extra   = '0;
        prev_hs    = vga_hsync;
        prev_vs    = vga_vsync;
        for (s = 0; s < frame_px; s++) begin
            if (s > 0) begin
                prev_hs = vga_hsync;
                prev_vs = vga_vsync;
                repeat (vga_pkg::pixel_div) @(negedge sys_clk);
            end
            if (prev_vs && !vga_vsync) vs_extra = vs_extra + 1'b1;
            // hsync follows the visible part of each line
            if (prev_hs && !vga_hsync) begin
                hs_pulses = hs_pulses + 1'b1;
                if (de_in_line != '0) begin
                    check_pos(de_in_line, vga_pkg::hpos_t'(vga_pkg::h_display),
                              "de ticks per line");
                    lines = lines + 1'b1;
                end
                de_in_line = '0;
            end
            if (vga_de) begin
                // raster order, pixel (x, y) lives at y*16+x
                idx = vga_pkg::fb_index_t'((p / vga_pkg::h_display) * 16 +
                                           (p % vga_pkg::h_display));
                check_pixel(vga_rgb, expected_image[idx][vga_pkg::rgb_w-1:0],
                            $sformatf("pixel x=%0d y=%0d", p % vga_pkg::h_display,
                                      p / vga_pkg::h_display));
                p          = p + 1;
                de_in_line = de_in_line + 1'b1;
            end
        end
        check_line(vs_extra, '0, "vsync pulses inside one frame");
        check_line(hs_pulses, vga_pkg::vpos_t'(vga_pkg::v_total), "hsync pulses per frame");
        check_line(lines, vga_pkg::vpos_t'(vga_pkg::v_display), "visible lines per frame");
        // next frame starts exactly one frame period later
        prev_vs = vga_vsync;
        repeat (vga_pkg::pixel_div) @(negedge sys_clk);
        check_level(prev_vs && !vga_vsync, 1'b1, "vsync period");
    endtask

    task automatic build_table();
        int i;
        for (i = 0; i < num_px; i++) begin
            tbl_idx[i] = vga_pkg::fb_index_t'(i);
            tbl_dat[i] = vga_pkg::sram_word_t'($random(seed));
        end
        // overwrites with high bits that the display must ignore
        tbl_idx[128] = 7'd0;
        tbl_dat[128] = 16'hffff;
        tbl_idx[129] = 7'd15;
        tbl_dat[129] = 16'hf000;
        tbl_idx[130] = 7'd112;
        tbl_dat[130] = 16'h0a5a;
        tbl_idx[131] = 7'd127;
        tbl_dat[131] = 16'h1234;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int                  i;
        logic [31:0]         rnd;
        vga_pkg::fb_index_t  ridx;
        vga_pkg::sram_word_t rd;
        vga_pkg::sram_word_t wdat;
        sys_rst  = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        build_table();
        for (i = 0; i < 10; i++) begin
            @(negedge sys_clk);
            check_reset_outputs();
        end
        sys_rst = 1'b0;
        check_reset_outputs();

        // write then read back each table entry
        for (i = 0; i < tbl_len; i++) begin
            write_word(tbl_idx[i], tbl_dat[i]);
            expected_image[tbl_idx[i]] = tbl_dat[i];
            read_word(tbl_idx[i], rd);
            check_word(rd, tbl_dat[i], $sformatf("readback of index %0d", tbl_idx[i]));
        end
        check_frame();

        // random traffic competing with the display fetch
        while (!vga_de) @(negedge sys_clk);
        for (i = 0; i < rand_ops; i++) begin
            rnd  = $random(seed);
            ridx = vga_pkg::fb_index_t'(rnd[14:8]);
            if (rnd[0]) begin
                wdat = vga_pkg::sram_word_t'($random(seed));
                write_word(ridx, wdat);
                expected_image[ridx] = wdat;
            end else begin
                read_word(ridx, rd);
                check_word(rd, expected_image[ridx],
                           $sformatf("random read of index %0d", ridx));
            end
        end
        check_frame();

        $display("all tests passed");
        $finish;
    end

    // watchdog sized from the table and six frames
    initial begin
        repeat (watchdog_cycles) @(posedge sys_clk);
        $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        abort_run();
    end

endmodule

`default_nettype wire

// File: vga_frame_buffer.f
design/vga_pkg.sv
design/vga_wb_port.sv
design/vga_sram_arbiter.sv
design/vga_scan_fetch.sv
design/vga_pixel_fifo.sv
design/vga_timing.sv
design/vga_frame_buffer.sv
tb/sram_model.sv
tb/tb_vga_frame_buffer.sv
